/* bench/cfg_boot_asserts.sv */
// Protocol checks for the boot configuration subsystem
// Command hold rule, writes in flight and done flag stability
// Bound into the boot top level

`timescale 1ns/1ps
`default_nettype none

module cfg_boot_asserts (
  input logic                             clk_i,
  input logic                             reset_i,
  input logic                             cmd_v_i,
  input logic                             cmd_yumi_i,
  input logic [cfg_map_pkg::ADDR_W-1:0]   cmd_addr_i,
  input logic [cfg_msg_pkg::DATA_W-1:0]   cmd_data_i,
  input logic                             resp_v_i,
  input logic                             done_i
);
  import cfg_msg_pkg::*;

  int outstanding; // Accepted commands not yet acknowledged
  int fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(cmd_yumi_i) - int'(resp_v_i);
  end

  // A pending command keeps v, address and data until yumi
  cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_yumi_i |=> cmd_v_i && $stable(cmd_addr_i) && $stable(cmd_data_i))
    else begin
      $error("command dropped or changed before yumi");
      fail_cnt++;
    end

  credits_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding <= MAX_CREDITS)
    else begin
      $error("more writes in flight than credits allow");
      fail_cnt++;
    end

  done_sticky: assert property (@(posedge clk_i) disable iff (reset_i) !$fell(done_i))
    else begin
      $error("done fell without a reset");
      fail_cnt++;
    end

endmodule

bind cfg_boot_top cfg_boot_asserts u_asserts (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .cmd_v_i    (cmd_if.v),
  .cmd_yumi_i (cmd_if.yumi),
  .cmd_addr_i (cmd_if.addr),
  .cmd_data_i (cmd_if.data),
  .resp_v_i   (resp_v),
  .done_i     (done_o)
);

`default_nettype wire

/* bench/cfg_boot_tb.sv */
// Directed testbench for the boot configuration subsystem
// Reset state, freeze phase, clean boot, microcode image, back-pressure
// Random stall pattern from an LCG, summary of test results

`timescale 1ns/1ps
`default_nettype none

module cfg_boot_tb;
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  localparam int          RESET_CYCLES   = 16;
  localparam int          FREEZE_TIMEOUT = 200;
  localparam int          DONE_TIMEOUT   = 3000;
  localparam logic [31:0] LCG_SEED       = 32'h3dd4_9331;

  logic                clk_i;
  logic                reset_i;
  logic                cmd_stall_i;
  logic                done_o;
  logic [NUM_TILES-1:0] freeze_o;
  logic [MODE_W-1:0]   icache_mode_o [NUM_TILES];
  logic [MODE_W-1:0]   dcache_mode_o [NUM_TILES];
  logic [MODE_W-1:0]   cce_mode_o    [NUM_TILES];
  logic [HIO_W-1:0]    hio_mask_o    [NUM_TILES];
  logic [TILE_W-1:0]   ucode_rd_tile_i;
  logic [UCODE_AW-1:0] ucode_rd_addr_i;
  logic [DATA_W-1:0]   ucode_rd_data_o;

  logic [DATA_W-1:0]   ucode_exp [UCODE_ELS]; // Image as read from the memory file
  logic [31:0]         lcg_state;
  int                  err_cnt;
  int                  tests_failed;
  int                  assert_errs;

  cfg_boot_top cfg_boot_top_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_stall_i     (cmd_stall_i),
    .done_o          (done_o),
    .freeze_o        (freeze_o),
    .icache_mode_o   (icache_mode_o),
    .dcache_mode_o   (dcache_mode_o),
    .cce_mode_o      (cce_mode_o),
    .hio_mask_o      (hio_mask_o),
    .ucode_rd_tile_i (ucode_rd_tile_i),
    .ucode_rd_addr_i (ucode_rd_addr_i),
    .ucode_rd_data_o (ucode_rd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #2; // Drive and sample away from the edge
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail with %0d errors", name, err_cnt - errs_before);
      tests_failed++;
    end
  endtask

  task automatic check_cleared(input string ctx);
    assert (done_o == 1'b0 && freeze_o == '0) else begin
      $display("ERR %0t: %s done %0b freeze %b, expected zero", $time, ctx, done_o, freeze_o);
      err_cnt++;
    end
    for (int t = 0; t < NUM_TILES; t++) begin
      assert (icache_mode_o[t] == '0 && dcache_mode_o[t] == '0 && cce_mode_o[t] == '0
              && hio_mask_o[t] == '0) else begin
        $display("ERR %0t: %s tile %0d mode or mask not zero", $time, ctx, t);
        err_cnt++;
      end
    end
  endtask

  task automatic apply_reset(input bit check);
    reset_i = 1'b1;
    cmd_stall_i = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      next_cycle();
      if (check)
        check_cleared("in reset");
    end
    reset_i = 1'b0;
  endtask

  task automatic wait_for_done(input bit random_stall, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < DONE_TIMEOUT) begin
      if (random_stall) begin
        lcg_state = lcg_next(lcg_state);
        cmd_stall_i = lcg_state[30];
      end
      next_cycle();
      seen = done_o;
      n++;
    end
    cmd_stall_i = 1'b0;
    if (!seen) begin
      $display("Timeout: done_o did not rise within %0d cycles", DONE_TIMEOUT);
      err_cnt++;
    end
  endtask

  task automatic check_final(input string ctx);
    assert (freeze_o == '0) else begin
      $display("ERR %0t: %s freeze %b, expected all clear", $time, ctx, freeze_o);
      err_cnt++;
    end
    for (int t = 0; t < NUM_TILES; t++) begin
      assert (icache_mode_o[t] == MODE_NORMAL && dcache_mode_o[t] == MODE_NORMAL) else begin
        $display("ERR %0t: %s tile %0d cache modes %0d %0d, expected %0d", $time, ctx, t,
                 icache_mode_o[t], dcache_mode_o[t], MODE_NORMAL);
        err_cnt++;
      end
      assert (cce_mode_o[t] == MODE_NORMAL) else begin
        $display("ERR %0t: %s tile %0d cce mode %0d, expected %0d", $time, ctx, t,
                 cce_mode_o[t], MODE_NORMAL);
        err_cnt++;
      end
      assert (hio_mask_o[t] == HIO_MASK) else begin
        $display("ERR %0t: %s tile %0d host mask %h, expected %h", $time, ctx, t,
                 hio_mask_o[t], HIO_MASK);
        err_cnt++;
      end
    end
  endtask

  task automatic check_ucode(input string ctx);
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int w = 0; w < UCODE_ELS; w++) begin
        ucode_rd_tile_i = TILE_W'(t);
        ucode_rd_addr_i = UCODE_AW'(w);
        #1; // Readback is combinational
        assert (ucode_rd_data_o == ucode_exp[w]) else begin
          $display("ERR %0t: %s tile %0d word %0d read %h, expected %h", $time, ctx, t, w,
                   ucode_rd_data_o, ucode_exp[w]);
          err_cnt++;
        end
      end
    end
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_cnt;
    apply_reset(1'b1);
    next_cycle();
    check_cleared("after reset");
    report_test("reset state", errs);
  endtask

  task automatic test_freeze_phase();
    int errs;
    int n;
    bit seen;
    errs = err_cnt;
    n = 0;
    seen = 1'b0;
    while (!seen && n < FREEZE_TIMEOUT) begin
      next_cycle();
      seen = (freeze_o == {NUM_TILES{1'b1}});
      n++;
    end
    if (!seen) begin
      $display("Timeout: freeze_o did not reach all ones within %0d cycles", FREEZE_TIMEOUT);
      err_cnt++;
    end else begin
      assert (done_o == 1'b0) else begin
        $display("ERR %0t: done_o already high during the freeze phase", $time);
        err_cnt++;
      end
    end
    report_test("freeze phase", errs);
  endtask

  task automatic test_clean_boot();
    int errs;
    bit seen;
    errs = err_cnt;
    wait_for_done(1'b0, seen);
    if (seen)
      check_final("clean boot");
    report_test("clean boot", errs);
  endtask

  task automatic test_ucode_image();
    int errs;
    errs = err_cnt;
    check_ucode("ucode image");
    report_test("microcode image", errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    bit seen;
    errs = err_cnt;
    apply_reset(1'b0);
    lcg_state = LCG_SEED;
    wait_for_done(1'b1, seen);
    if (seen) begin
      check_final("back-pressure");
      check_ucode("back-pressure");
    end
    report_test("back-pressure", errs);
  endtask

  initial begin
    reset_i = 1'b1;
    cmd_stall_i = 1'b0;
    ucode_rd_tile_i = '0;
    ucode_rd_addr_i = '0;
    lcg_state = LCG_SEED;
    err_cnt = 0;
    tests_failed = 0;
    $readmemb("cfg_ucode.mem", ucode_exp);

    test_reset_state();
    test_freeze_phase();
    test_clean_boot();
    test_ucode_image();
    test_back_pressure();

    assert_errs = cfg_boot_top_inst.u_asserts.fail_cnt; // Bound protocol checks
    $display("tests run 5, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_failed, err_cnt, assert_errs);
    if (err_cnt == 0 && assert_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* cfg_boot_top.f */
verilog/cfg_map_pkg.sv
verilog/cfg_msg_pkg.sv
verilog/cfg_if.sv
verilog/cfg_loader.sv
verilog/cfg_cmd_decode.sv
verilog/cfg_tile_regs.sv
verilog/cfg_boot_top.sv
bench/cfg_boot_asserts.sv
bench/cfg_boot_tb.sv

/* cfg_ucode.mem */
// Boot microcode image, one 64-bit word per line in binary, word 0 first
// Bytes are separated by underscores, most significant byte on the left
10100101_00000000_00000000_00000000_00000000_00000000_00000000_00000001
11110000_00001111_11001100_00110011_10101010_01010101_00000000_00000010
00010010_00110100_01010110_01111000_10011010_10111100_11011110_11110000
11111111_00000000_11111111_00000000_00000001_00000010_00000100_00001000
01111110_10000001_01000010_00100100_00011000_00000000_11100111_00000011
00000000_00000000_00000000_00000000_11011110_10101101_10111110_11101111
10000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000
01010101_10101010_01010101_10101010_00110011_11001100_00001111_11110000

/* run.sh */
#!/bin/sh
# Build the boot configuration testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cfg_boot_tb \
  -f cfg_boot_top.f -o sim_cfg_boot || exit 1
out=$(./obj_dir/sim_cfg_boot)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1

/* verilog/cfg_boot_top.sv */
// Boot configuration subsystem top level
// Loader, command decode and tile register execute stage

`timescale 1ns/1ps
`default_nettype none

module cfg_boot_top (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              cmd_stall_i, // Holds yumi low
  output logic                              done_o,
  output logic [cfg_map_pkg::NUM_TILES-1:0] freeze_o,
  output logic [cfg_msg_pkg::MODE_W-1:0]    icache_mode_o [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::MODE_W-1:0]    dcache_mode_o [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::MODE_W-1:0]    cce_mode_o    [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::HIO_W-1:0]     hio_mask_o    [cfg_map_pkg::NUM_TILES],
  input  logic [cfg_map_pkg::TILE_W-1:0]    ucode_rd_tile_i,
  input  logic [cfg_msg_pkg::UCODE_AW-1:0]  ucode_rd_addr_i,
  output logic [cfg_msg_pkg::DATA_W-1:0]    ucode_rd_data_o
);

  cfg_cmd_if  cmd_if ();
  cfg_exec_if exec_if ();
  logic       resp_v;

  cfg_loader u_loader (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd      (cmd_if.source),
    .resp_v_i (resp_v),
    .done_o   (done_o)
  );

  cfg_cmd_decode u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_stall_i (cmd_stall_i),
    .cmd         (cmd_if.sink),
    .exec        (exec_if.source)
  );

  cfg_tile_regs u_exec (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .exec            (exec_if.sink),
    .resp_v_o        (resp_v),
    .freeze_o        (freeze_o),
    .icache_mode_o   (icache_mode_o),
    .dcache_mode_o   (dcache_mode_o),
    .cce_mode_o      (cce_mode_o),
    .hio_mask_o      (hio_mask_o),
    .ucode_rd_tile_i (ucode_rd_tile_i),
    .ucode_rd_addr_i (ucode_rd_addr_i),
    .ucode_rd_data_o (ucode_rd_data_o)
  );

endmodule

`default_nettype wire

/* verilog/cfg_cmd_decode.sv */
// Command decode stage
// Accepts loader commands and registers the decoded fields

`timescale 1ns/1ps
`default_nettype none

module cfg_cmd_decode (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_stall_i,
  cfg_cmd_if.sink    cmd,
  cfg_exec_if.source exec
);
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  logic              v_r;
  logic [TILE_W-1:0] tile_r;
  logic              sel_r;
  logic [REG_W-1:0]  index_r;
  logic [DATA_W-1:0] data_r;

  assign cmd.yumi = cmd.v & ~cmd_stall_i;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      v_r <= 1'b0;
    else
      v_r <= cmd.yumi;
  end

  always_ff @(posedge clk_i) begin
    if (cmd.yumi) begin
      tile_r  <= cmd.addr.regs.tile;
      sel_r   <= cmd.addr.regs.ucode_sel;
      index_r <= cmd.addr.regs.reg_idx; // Word index sits in the same bits
      data_r  <= cmd.data;
    end
  end

  assign exec.v         = v_r;
  assign exec.tile      = tile_r;
  assign exec.ucode_sel = sel_r;
  assign exec.index     = index_r;
  assign exec.data      = data_r;

endmodule

`default_nettype wire

/* verilog/cfg_if.sv */
// Command link from loader to decode, valid/yumi handshake
// Execute link from decode to tile registers, no back-pressure

`timescale 1ns/1ps
`default_nettype none

interface cfg_cmd_if;
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  logic              v;
  logic              yumi;
  cfg_addr_u         addr;
  logic [DATA_W-1:0] data;

  modport source (output v, addr, data, input yumi);
  modport sink   (input v, addr, data, output yumi);
endinterface

interface cfg_exec_if;
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  logic              v;
  logic [TILE_W-1:0] tile;
  logic              ucode_sel;
  logic [REG_W-1:0]  index;
  logic [DATA_W-1:0] data;

  modport source (output v, tile, ucode_sel, index, data);
  modport sink   (input v, tile, ucode_sel, index, data);
endinterface

`default_nettype wire

/* verilog/cfg_loader.sv */
// Boot sequencer for the tile configuration network
// Microcode boot ROM, credit counter, tile, word and sync counters

`timescale 1ns/1ps
`default_nettype none

module cfg_loader (
  input  logic     clk_i,
  input  logic     reset_i,
  cfg_cmd_if.source cmd,
  input  logic     resp_v_i,
  output logic     done_o
);
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  typedef enum logic [3:0] {
    RESET, FREEZE_SET, SEND_UCODE, ICACHE, DCACHE, CCE,
    SYNC, HIO, FREEZE_CLR, WAIT_CREDITS, DONE
  } state_e;

  state_e state_r;
  state_e wr_next; // Successor once the last tile is written

  logic [DATA_W-1:0]   ucode_rom [UCODE_ELS];
  logic [TILE_W-1:0]   tile_cnt_r;
  logic [UCODE_AW-1:0] ucode_cnt_r;
  logic [SYNC_W-1:0]   sync_cnt_r;
  logic [CREDIT_W-1:0] credit_r;
  logic                wr_v;
  cfg_addr_u           addr;
  logic [DATA_W-1:0]   data;

  initial $readmemb(UCODE_FILE, ucode_rom);

  wire tile_last     = (tile_cnt_r == TILE_W'(NUM_TILES - 1));
  wire ucode_last    = (ucode_cnt_r == UCODE_AW'(UCODE_ELS - 1));
  wire sync_done     = (sync_cnt_r == SYNC_W'(SYNC_CYCLES - 1));
  wire credits_full  = (credit_r == CREDIT_W'(MAX_CREDITS));
  wire credits_empty = (credit_r == '0);

  // Writes in flight, up on yumi and down on ack
  always_ff @(posedge clk_i) begin
    if (reset_i)
      credit_r <= '0;
    else if (cmd.yumi && !resp_v_i)
      credit_r <= credit_r + 1'b1;
    else if (resp_v_i && !cmd.yumi)
      credit_r <= credit_r - 1'b1;
  end

  always_comb begin
    wr_v    = 1'b0;
    wr_next = state_r;
    addr    = '0;
    addr.regs.tile = tile_cnt_r;
    data    = '0;
    case (state_r)
      FREEZE_SET: begin
        wr_v = 1'b1;
        wr_next = SEND_UCODE;
        addr.regs.reg_idx = REG_FREEZE;
        data = DATA_W'(1);
      end
      SEND_UCODE: begin
        wr_v = 1'b1;
        addr.ucode.ucode_sel = 1'b1;
        addr.ucode.word_idx = REG_W'(ucode_cnt_r);
        data = ucode_rom[ucode_cnt_r];
      end
      ICACHE: begin
        wr_v = 1'b1;
        wr_next = DCACHE;
        addr.regs.reg_idx = REG_ICACHE_MODE;
        data = DATA_W'(MODE_NORMAL);
      end
      DCACHE: begin
        wr_v = 1'b1;
        wr_next = CCE;
        addr.regs.reg_idx = REG_DCACHE_MODE;
        data = DATA_W'(MODE_NORMAL);
      end
      CCE: begin
        wr_v = credits_empty; // Earlier writes must land first
        wr_next = SYNC;
        addr.regs.reg_idx = REG_CCE_MODE;
        data = DATA_W'(MODE_NORMAL);
      end
      HIO: begin
        wr_v = credits_empty;
        wr_next = FREEZE_CLR;
        addr.regs.reg_idx = REG_HIO_MASK;
        data = DATA_W'(HIO_MASK);
      end
      FREEZE_CLR: begin
        wr_v = 1'b1;
        wr_next = WAIT_CREDITS;
        addr.regs.reg_idx = REG_FREEZE;
      end
      default: ;
    endcase
  end

  assign cmd.v    = wr_v & ~credits_full;
  assign cmd.addr = addr;
  assign cmd.data = data;
  assign done_o   = (state_r == DONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= RESET;
      tile_cnt_r  <= '0;
      ucode_cnt_r <= '0;
      sync_cnt_r  <= '0;
    end else begin
      case (state_r)
        RESET: state_r <= FREEZE_SET;
        SEND_UCODE: if (cmd.yumi) begin
          ucode_cnt_r <= ucode_last ? '0 : ucode_cnt_r + 1'b1;
          if (ucode_last) begin
            tile_cnt_r <= tile_last ? '0 : tile_cnt_r + 1'b1;
            if (tile_last)
              state_r <= ICACHE;
          end
        end
        SYNC: begin
          sync_cnt_r <= sync_done ? '0 : sync_cnt_r + 1'b1;
          if (sync_done)
            state_r <= HIO;
        end
        WAIT_CREDITS: if (credits_empty) state_r <= DONE;
        DONE: ;
        default: if (cmd.yumi) begin // One write per tile
          tile_cnt_r <= tile_last ? '0 : tile_cnt_r + 1'b1;
          if (tile_last)
            state_r <= wr_next;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/cfg_map_pkg.sv */
// Configuration address map
// Tile count, field widths and register indices
// Packed union with register and microcode views of an address

`default_nettype none

package cfg_map_pkg;

  localparam int NUM_TILES = 2;
  localparam int TILE_W    = 1;
  localparam int REG_W     = 4; // Register or microcode word index
  localparam int ADDR_W    = 8;
  localparam int SPARE_W   = ADDR_W - TILE_W - 1 - REG_W;

  localparam logic [REG_W-1:0] REG_FREEZE      = 4'd0;
  localparam logic [REG_W-1:0] REG_ICACHE_MODE = 4'd1;
  localparam logic [REG_W-1:0] REG_DCACHE_MODE = 4'd2;
  localparam logic [REG_W-1:0] REG_CCE_MODE    = 4'd3;
  localparam logic [REG_W-1:0] REG_HIO_MASK    = 4'd4;

  typedef struct packed {
    logic [TILE_W-1:0]  tile;
    logic               ucode_sel; // Low selects the register file
    logic [SPARE_W-1:0] spare;
    logic [REG_W-1:0]   reg_idx;
  } cfg_reg_addr_s;

  typedef struct packed {
    logic [TILE_W-1:0]  tile;
    logic               ucode_sel; // High selects the microcode RAM
    logic [SPARE_W-1:0] spare;
    logic [REG_W-1:0]   word_idx;
  } cfg_ucode_addr_s;

  typedef union packed {
    cfg_reg_addr_s   regs;
    cfg_ucode_addr_s ucode;
  } cfg_addr_u;

endpackage

`default_nettype wire

/* verilog/cfg_msg_pkg.sv */
// Configuration message contents
// Data width, mode and mask encodings
// Credit, microcode and boot script constants

`default_nettype none

package cfg_msg_pkg;

  localparam int DATA_W = 64;

  localparam int MODE_W = 2;
  localparam logic [MODE_W-1:0] MODE_UNCACHED = 2'd0; // Value out of reset
  localparam logic [MODE_W-1:0] MODE_NORMAL   = 2'd1;

  localparam int HIO_W = 8;
  localparam logic [HIO_W-1:0] HIO_MASK = 8'h01; // Host I/O 0 only

  localparam int UCODE_ELS = 8;
  localparam int UCODE_AW  = $clog2(UCODE_ELS);
  localparam string UCODE_FILE = "cfg_ucode.mem";

  localparam int MAX_CREDITS = 4;
  localparam int CREDIT_W    = $clog2(MAX_CREDITS + 1);

  localparam int SYNC_CYCLES = 16;
  localparam int SYNC_W      = $clog2(SYNC_CYCLES);

endpackage

`default_nettype wire

/* verilog/cfg_tile_regs.sv */
// Execute stage of the configuration network
// Per-tile freeze, mode and host mask registers
// Per-tile microcode RAM with combinational readback
// One acknowledge pulse per executed write

`timescale 1ns/1ps
`default_nettype none

module cfg_tile_regs (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  cfg_exec_if.sink                              exec,
  output logic                                  resp_v_o,
  output logic [cfg_map_pkg::NUM_TILES-1:0]     freeze_o,
  output logic [cfg_msg_pkg::MODE_W-1:0]        icache_mode_o [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::MODE_W-1:0]        dcache_mode_o [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::MODE_W-1:0]        cce_mode_o    [cfg_map_pkg::NUM_TILES],
  output logic [cfg_msg_pkg::HIO_W-1:0]         hio_mask_o    [cfg_map_pkg::NUM_TILES],
  input  logic [cfg_map_pkg::TILE_W-1:0]        ucode_rd_tile_i,
  input  logic [cfg_msg_pkg::UCODE_AW-1:0]      ucode_rd_addr_i,
  output logic [cfg_msg_pkg::DATA_W-1:0]        ucode_rd_data_o
);
  import cfg_map_pkg::*;
  import cfg_msg_pkg::*;

  logic [NUM_TILES-1:0] freeze_r;
  logic [MODE_W-1:0]    icache_mode_r [NUM_TILES];
  logic [MODE_W-1:0]    dcache_mode_r [NUM_TILES];
  logic [MODE_W-1:0]    cce_mode_r    [NUM_TILES];
  logic [HIO_W-1:0]     hio_mask_r    [NUM_TILES];
  logic [DATA_W-1:0]    ucode_mem     [NUM_TILES][UCODE_ELS];
  logic                 resp_v_r;

  wire reg_we   = exec.v & ~exec.ucode_sel;
  wire ucode_we = exec.v & exec.ucode_sel;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
      freeze_r <= '0;
      for (int t = 0; t < NUM_TILES; t++) begin
        icache_mode_r[t] <= MODE_UNCACHED;
        dcache_mode_r[t] <= MODE_UNCACHED;
        cce_mode_r[t]    <= MODE_UNCACHED;
        hio_mask_r[t]    <= '0;
      end
    end else begin
      resp_v_r <= exec.v; // Ack follows the write by one cycle
      if (reg_we) begin
        case (exec.index)
          REG_FREEZE:      freeze_r[exec.tile]      <= exec.data[0];
          REG_ICACHE_MODE: icache_mode_r[exec.tile] <= exec.data[MODE_W-1:0];
          REG_DCACHE_MODE: dcache_mode_r[exec.tile] <= exec.data[MODE_W-1:0];
          REG_CCE_MODE:    cce_mode_r[exec.tile]    <= exec.data[MODE_W-1:0];
          REG_HIO_MASK:    hio_mask_r[exec.tile]    <= exec.data[HIO_W-1:0];
          default: ; // Unmapped index is dropped
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ucode_we)
      ucode_mem[exec.tile][exec.index[UCODE_AW-1:0]] <= exec.data;
  end

  assign ucode_rd_data_o = ucode_mem[ucode_rd_tile_i][ucode_rd_addr_i];

  assign resp_v_o      = resp_v_r;
  assign freeze_o      = freeze_r;
  assign icache_mode_o = icache_mode_r;
  assign dcache_mode_o = dcache_mode_r;
  assign cce_mode_o    = cce_mode_r;
  assign hio_mask_o    = hio_mask_r;

endmodule

`default_nettype wire
